// File: hw/cpu_pkg.sv
// Shared word, address, opcode, bus source and timing state types plus the default RAM size
`default_nettype none

package cpu_pkg;

    // Data and address widths of the machine
    typedef logic [7:0] word_t;   // Bus word, RAM word, register contents
    typedef logic [3:0] addr_t;   // RAM address and PC value

    localparam int RAM_BYTES_DEFAULT = 16;  // Full 4-bit address space

    // Opcode sits in the high nibble of an instruction byte
    typedef enum logic [3:0] {
        OP_LDA = 4'd0,   // ACC <- RAM[operand]
        OP_ADD = 4'd1,   // ACC <- ACC + RAM[operand]
        OP_SUB = 4'd2,   // ACC <- ACC - RAM[operand]
        OP_STA = 4'd3,   // RAM[operand] <- ACC
        OP_LDI = 4'd4,   // ACC <- operand
        OP_JMP = 4'd5,   // PC <- operand
        OP_JC  = 4'd6,   // Jump if carry / no borrow
        OP_JZ  = 4'd7,   // Jump if zero
        OP_OUT = 4'd14,  // Output port <- ACC
        OP_HLT = 4'd15   // Stop and go idle
    } opcode_t;

    // Which block drives the internal bus
    typedef enum logic [2:0] {
        BUS_NONE = 3'd0,
        BUS_PC   = 3'd1,
        BUS_RAM  = 3'd2,
        BUS_IR   = 3'd3,  // Operand nibble of the instruction register
        BUS_ACC  = 3'd4,
        BUS_ALU  = 3'd5
    } bus_src_t;

    // Timing states of the sequencer
    typedef enum logic [2:0] {
        T0     = 3'd0,  // PC -> MAR
        T1     = 3'd1,  // RAM -> IR, PC + 1
        T2     = 3'd2,  // Execute steps
        T3     = 3'd3,
        T4     = 3'd4,
        T_IDLE = 3'd7   // Not running, program port open
    } tstate_t;

endpackage

`default_nettype wire

// File: hw/program_counter.sv
// 4-bit program counter with clear, increment and jump load from the bus
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  wire            clk,
    input  wire            reset,
    input  wire            clear,    // Start of a new run
    input  wire            pc_inc,   // Step to next instruction
    input  wire            pc_load,  // Jump target on bus
    input  cpu_pkg::word_t bus_in,
    output cpu_pkg::addr_t pc
);

    // Jump wins over increment, they never coincide in the microcode anyway
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= bus_in[3:0];             // Only low nibble addresses RAM
        end else if (pc_inc) begin
            pc <= pc + 4'd1;               // Wraps at 15
        end
    end

endmodule

`default_nettype wire

// File: hw/memory_unit.sv
// Memory address register, parameterized RAM with STA write path and host program port
`timescale 1ns/1ps
`default_nettype none

module memory_unit #(
    parameter int RAM_BYTES = 16   // 8 or 16
) (
    input  wire            clk,
    input  wire            reset,
    input  wire            mar_load,    // Capture address from bus
    input  wire            ram_write,   // STA store
    input  cpu_pkg::word_t bus_in,
    input  wire            prog_valid,  // Host program port
    input  wire            prog_ready,  // High only while CPU idles
    input  cpu_pkg::addr_t prog_addr,
    input  cpu_pkg::word_t prog_data,
    output cpu_pkg::word_t ram_data     // Async read at MAR
);

    localparam int AW = $clog2(RAM_BYTES);  // Index bits actually stored

    cpu_pkg::addr_t mar;                    // Memory address register
    cpu_pkg::word_t mem [RAM_BYTES];        // Storage array

    logic mar_in_range;
    logic prog_in_range;
    logic prog_fire;

    // Addresses past the end of a small RAM read zero and drop writes
    assign mar_in_range  = (32'(mar) < RAM_BYTES);
    assign prog_in_range = (32'(prog_addr) < RAM_BYTES);
    assign prog_fire     = prog_valid && prog_ready;   // Handshake

    always_ff @(posedge clk) begin
        if (reset) begin
            mar <= '0;
        end else if (mar_load) begin
            mar <= bus_in[3:0];
        end
    end

    // Host writes only happen while idle, so they never meet an STA
    always_ff @(posedge clk) begin
        if (prog_fire) begin
            if (prog_in_range) begin
                mem[prog_addr[AW-1:0]] <= prog_data;
            end
        end else if (ram_write && mar_in_range) begin
            mem[mar[AW-1:0]] <= bus_in;    // STA path
        end
    end

    // Combinational read so T1 sees the word the MAR picked in T0
    assign ram_data = mar_in_range ? mem[mar[AW-1:0]] : '0;

endmodule

`default_nettype wire

// File: hw/arith_unit.sv
// Accumulator, B register, adder/subtractor and the registered carry and zero flags
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
    input  wire            clk,
    input  wire            reset,
    input  wire            acc_load,
    input  wire            b_load,
    input  wire            alu_sub,     // 1 = ACC - B
    input  wire            flags_load,
    input  cpu_pkg::word_t bus_in,
    output cpu_pkg::word_t acc,
    output cpu_pkg::word_t alu_result,
    output logic           carry,
    output logic           zero
);

    cpu_pkg::word_t b_reg;
    cpu_pkg::word_t b_operand;
    logic [8:0]     sum;        // Carry in bit 8

    always_ff @(posedge clk) begin
        if (reset) begin
            acc   <= '0;
            b_reg <= '0;
        end else begin
            if (acc_load) acc <= bus_in;
            if (b_load) b_reg <= bus_in;
        end
    end

    // Subtract as ACC + ~B + 1, so bit 8 reads as no-borrow
    assign b_operand  = alu_sub ? ~b_reg : b_reg;
    assign sum        = {1'b0, acc} + {1'b0, b_operand} + {8'd0, alu_sub};
    assign alu_result = sum[7:0];

    // Flags only move on ADD/SUB writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (flags_load) begin
            carry <= sum[8];
            zero  <= (sum[7:0] == 8'd0);
        end
    end

endmodule

`default_nettype wire

// File: hw/output_port.sv
// One-entry output buffer with valid/ready hand-off and full indication for the sequencer
`timescale 1ns/1ps
`default_nettype none

module output_port (
    input  wire            clk,
    input  wire            reset,
    input  wire            out_load,   // OUT instruction writes ACC here
    input  cpu_pkg::word_t bus_in,
    input  wire            out_ready,
    output logic           out_valid,
    output cpu_pkg::word_t out_data,
    output logic           out_full    // OUT must stall
);

    // Full only while the word is held and not taken this cycle
    assign out_full = out_valid && !out_ready;

    // A load in the hand-off cycle refills the slot at once
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (out_load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;             // Accepted, or was empty
        end
    end

    // Data held steady until accepted, sequencer never loads while full
    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data <= bus_in;
        end
    end

endmodule

`default_nettype wire

// File: hw/control_block.sv
// Instruction register, timing-state sequencer, microcode decode and run/idle control
`timescale 1ns/1ps
`default_nettype none

module control_block (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 start,      // Pulse while idle to run
    input  cpu_pkg::word_t      bus_in,
    input  wire                 carry,      // Registered ALU flags
    input  wire                 zero,
    input  wire                 out_full,   // Output buffer still held
    output logic                prog_ready,
    output logic                halted,
    output cpu_pkg::bus_src_t   bus_src,
    output logic                pc_inc,
    output logic                pc_load,
    output logic                mar_load,
    output logic                ram_write,
    output logic                ir_load,
    output logic                acc_load,
    output logic                b_load,
    output logic                alu_sub,
    output logic                flags_load,
    output logic                out_load,
    output cpu_pkg::addr_t      operand,    // IR low nibble for the bus
    output logic                pc_clear
);

    cpu_pkg::word_t   ir;
    cpu_pkg::tstate_t state;
    cpu_pkg::tstate_t state_next;
    cpu_pkg::opcode_t opcode;

    assign opcode  = cpu_pkg::opcode_t'(ir[7:4]);
    assign operand = ir[3:0];

    // Idle doubles as halted, both clear on start
    assign prog_ready = (state == cpu_pkg::T_IDLE);
    assign halted     = (state == cpu_pkg::T_IDLE);
    assign pc_clear   = (state == cpu_pkg::T_IDLE) && start;  // Run from address 0

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= bus_in;                  // Fetched instruction byte
        end
    end

    always_ff @(posedge clk) begin
        if (reset) state <= cpu_pkg::T_IDLE;
        else       state <= state_next;
    end

    // Sequencer: HLT and OUT finish in T2, OUT waits there while full
    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::T_IDLE: if (start) state_next = cpu_pkg::T0;
            cpu_pkg::T0:     state_next = cpu_pkg::T1;
            cpu_pkg::T1:     state_next = cpu_pkg::T2;
            cpu_pkg::T2: begin
                if (opcode == cpu_pkg::OP_HLT)      state_next = cpu_pkg::T_IDLE;
                else if (opcode == cpu_pkg::OP_OUT) state_next = out_full ? cpu_pkg::T2
                                                                          : cpu_pkg::T0;
                else                                state_next = cpu_pkg::T3;
            end
            cpu_pkg::T3:     state_next = cpu_pkg::T4;
            cpu_pkg::T4:     state_next = cpu_pkg::T0;
            default:         state_next = cpu_pkg::T_IDLE;  // Unused codes recover
        endcase
    end

    // Microcode, everything low unless a step asks for it
    always_comb begin
        bus_src    = cpu_pkg::BUS_NONE;
        pc_inc     = 1'b0;
        pc_load    = 1'b0;
        mar_load   = 1'b0;
        ram_write  = 1'b0;
        ir_load    = 1'b0;
        acc_load   = 1'b0;
        b_load     = 1'b0;
        alu_sub    = 1'b0;
        flags_load = 1'b0;
        out_load   = 1'b0;
        case (state)
            cpu_pkg::T0: begin
                bus_src  = cpu_pkg::BUS_PC;
                mar_load = 1'b1;
            end
            cpu_pkg::T1: begin
                bus_src = cpu_pkg::BUS_RAM;
                ir_load = 1'b1;
                pc_inc  = 1'b1;
            end
            cpu_pkg::T2: begin
                case (opcode)
                    cpu_pkg::OP_LDA, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_STA: begin
                        bus_src  = cpu_pkg::BUS_IR;      // Operand address to MAR
                        mar_load = 1'b1;
                    end
                    cpu_pkg::OP_LDI: begin
                        bus_src  = cpu_pkg::BUS_IR;
                        acc_load = 1'b1;
                    end
                    cpu_pkg::OP_JMP: begin
                        bus_src = cpu_pkg::BUS_IR;
                        pc_load = 1'b1;
                    end
                    cpu_pkg::OP_JC: begin
                        bus_src = cpu_pkg::BUS_IR;
                        pc_load = carry;                 // Not taken falls through
                    end
                    cpu_pkg::OP_JZ: begin
                        bus_src = cpu_pkg::BUS_IR;
                        pc_load = zero;
                    end
                    cpu_pkg::OP_OUT: begin
                        bus_src  = cpu_pkg::BUS_ACC;
                        out_load = !out_full;            // Hold off until slot frees
                    end
                    default: ;                           // HLT and NOPs
                endcase
            end
            cpu_pkg::T3: begin
                case (opcode)
                    cpu_pkg::OP_LDA: begin
                        bus_src  = cpu_pkg::BUS_RAM;
                        acc_load = 1'b1;
                    end
                    cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: begin
                        bus_src = cpu_pkg::BUS_RAM;      // Operand into B
                        b_load  = 1'b1;
                    end
                    cpu_pkg::OP_STA: begin
                        bus_src   = cpu_pkg::BUS_ACC;
                        ram_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            cpu_pkg::T4: begin
                if (opcode == cpu_pkg::OP_ADD || opcode == cpu_pkg::OP_SUB) begin
                    bus_src    = cpu_pkg::BUS_ALU;       // Result back to ACC
                    acc_load   = 1'b1;
                    flags_load = 1'b1;
                    alu_sub    = (opcode == cpu_pkg::OP_SUB);
                end
            end
            default: ;                                   // Idle drives nothing
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
// CPU top level with block instances and the one-hot bus multiplexer
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int RAM_BYTES = cpu_pkg::RAM_BYTES_DEFAULT
) (
    input  wire            clk,
    input  wire            reset,
    input  wire            start,
    input  wire            prog_valid,
    input  cpu_pkg::addr_t prog_addr,
    input  cpu_pkg::word_t prog_data,
    input  wire            out_ready,
    output logic           prog_ready,
    output logic           halted,
    output logic           out_valid,
    output cpu_pkg::word_t out_data
);

    cpu_pkg::word_t    bus;
    cpu_pkg::bus_src_t bus_src;
    cpu_pkg::addr_t    pc;
    cpu_pkg::addr_t    operand;
    cpu_pkg::word_t    ram_data;
    cpu_pkg::word_t    acc;
    cpu_pkg::word_t    alu_result;

    logic pc_inc, pc_load, pc_clear;
    logic mar_load, ram_write, ir_load;
    logic acc_load, b_load, alu_sub, flags_load;
    logic out_load, out_full;
    logic carry, zero;
    logic sel_pc, sel_ram, sel_ir, sel_acc, sel_alu;   // One-hot bus selects

    // Stands in for the tri-state bus, no select gives zero
    always_comb begin
        sel_pc  = (bus_src == cpu_pkg::BUS_PC);
        sel_ram = (bus_src == cpu_pkg::BUS_RAM);
        sel_ir  = (bus_src == cpu_pkg::BUS_IR);
        sel_acc = (bus_src == cpu_pkg::BUS_ACC);
        sel_alu = (bus_src == cpu_pkg::BUS_ALU);
        bus = ({8{sel_pc}}  & {4'd0, pc})
            | ({8{sel_ram}} & ram_data)
            | ({8{sel_ir}}  & {4'd0, operand})
            | ({8{sel_acc}} & acc)
            | ({8{sel_alu}} & alu_result);
    end

    program_counter u_program_counter (
        .clk(clk), .reset(reset), .clear(pc_clear),
        .pc_inc(pc_inc), .pc_load(pc_load), .bus_in(bus), .pc(pc)
    );

    memory_unit #(
        .RAM_BYTES(RAM_BYTES)
    ) u_memory_unit (
        .clk(clk), .reset(reset), .mar_load(mar_load), .ram_write(ram_write),
        .bus_in(bus), .prog_valid(prog_valid), .prog_ready(prog_ready),
        .prog_addr(prog_addr), .prog_data(prog_data), .ram_data(ram_data)
    );

    arith_unit u_arith_unit (
        .clk(clk), .reset(reset), .acc_load(acc_load), .b_load(b_load),
        .alu_sub(alu_sub), .flags_load(flags_load), .bus_in(bus),
        .acc(acc), .alu_result(alu_result), .carry(carry), .zero(zero)
    );

    output_port u_output_port (
        .clk(clk), .reset(reset), .out_load(out_load), .bus_in(bus),
        .out_ready(out_ready), .out_valid(out_valid), .out_data(out_data),
        .out_full(out_full)
    );

    control_block u_control_block (
        .clk(clk), .reset(reset), .start(start), .bus_in(bus),
        .carry(carry), .zero(zero), .out_full(out_full),
        .prog_ready(prog_ready), .halted(halted), .bus_src(bus_src),
        .pc_inc(pc_inc), .pc_load(pc_load), .mar_load(mar_load),
        .ram_write(ram_write), .ir_load(ir_load), .acc_load(acc_load),
        .b_load(b_load), .alu_sub(alu_sub), .flags_load(flags_load),
        .out_load(out_load), .operand(operand), .pc_clear(pc_clear)
    );

endmodule

`default_nettype wire

// File: testbench/cpu_tb.sv
// Testbench for the accumulator CPU with random programs, ISA model, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int NUM_TESTS    = 24;
    localparam int RESET_CYCLES = 16;
    // Program writes plus 16 instructions of 5 cycles per test with room for stalls
    localparam int CYCLE_LIMIT  = NUM_TESTS * (16 + 16 * 5 * 4) + RESET_CYCLES;

    logic           clk;
    logic           reset;
    logic           start;
    logic           prog_valid;
    cpu_pkg::addr_t prog_addr;
    cpu_pkg::word_t prog_data;
    logic           out_ready;
    logic           prog_ready;
    logic           halted;
    logic           out_valid;
    cpu_pkg::word_t out_data;

    logic [31:0]    rng_state;
    cpu_pkg::word_t prog_mem [16];    // Image for the next run
    cpu_pkg::word_t exp_q [$];        // Words the model emits
    cpu_pkg::word_t got_q [$];        // Words taken from the output port
    cpu_pkg::word_t m_acc;            // Model state survives between runs like the DUT registers
    logic           m_carry;
    logic           m_zero;
    logic           smp_halted;       // Falling edge samples
    logic           smp_prog_ready;
    logic           smp_out_valid;
    logic           held_valid;       // Word was stalled at the last sample
    cpu_pkg::word_t held_data;
    logic           stall_mode;       // Long out_ready low stretches
    int             ready_hold;
    int             error_count;
    int             cycle_count;

    cpu_top #(
        .RAM_BYTES(cpu_pkg::RAM_BYTES_DEFAULT)
    ) u_cpu_top (
        .clk(clk), .reset(reset), .start(start), .prog_valid(prog_valid),
        .prog_addr(prog_addr), .prog_data(prog_data), .out_ready(out_ready),
        .prog_ready(prog_ready), .halted(halted), .out_valid(out_valid),
        .out_data(out_data)
    );

    always #20 clk = ~clk;            // 40 ns period

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic cpu_pkg::word_t make_instr(logic [3:0] op, logic [3:0] arg);
        return {op, arg};             // Opcode high nibble, operand low
    endfunction

    task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(int got, int exp);
        if (got != exp) begin
            $display("Wrong number of output words: %0d seen, %0d expected", got, exp);
            error_count++;
        end
    endtask

    // Sample at the falling edge, then drive out_ready on the rising edge
    task automatic step_cycle();
        logic [31:0] r;
        @(negedge clk);
        smp_halted     = halted;
        smp_prog_ready = prog_ready;
        smp_out_valid  = out_valid;
        if (held_valid && out_valid) check_word("out_data", out_data, held_data);
        if (out_valid && out_ready) got_q.push_back(out_data);   // Taken at the next edge
        held_valid = out_valid && !out_ready;
        held_data  = out_data;
        @(posedge clk);
        r = next_random();
        if (ready_hold > 0) begin
            ready_hold--;                                        // Keep the current level
        end else if (stall_mode) begin
            out_ready  <= r[0];
            ready_hold = int'(r[6:4]);
        end else begin
            out_ready <= (r[1:0] != 2'b00);                      // Mostly ready
        end
    endtask

    task automatic fill_data();
        logic [31:0] r;
        for (int a = 8; a < 16; a++) begin
            r = next_random();
            prog_mem[4'(a)] = r[7:0];
        end
    endtask

    // Pairs of LDI and OUT, then HLT
    task automatic gen_ldi_out();
        logic [31:0] r;
        for (int i = 0; i < 7; i++) begin
            r = next_random();
            prog_mem[4'(2 * i)]     = make_instr(cpu_pkg::OP_LDI, r[3:0]);
            prog_mem[4'(2 * i + 1)] = make_instr(cpu_pkg::OP_OUT, 4'd0);
        end
        prog_mem[14] = make_instr(cpu_pkg::OP_HLT, 4'd0);
        prog_mem[15] = 8'h00;
    endtask

    // Straight-line code in 0 to 7, data in 8 to 15
    task automatic gen_arith();
        logic [31:0] r;
        logic [3:0]  op;
        fill_data();
        r = next_random();
        prog_mem[0] = make_instr(cpu_pkg::OP_LDA, {1'b1, r[2:0]});
        for (int a = 1; a < 6; a++) begin
            r = next_random();
            case (int'(r[7:0]) % 5)
                0:       op = cpu_pkg::OP_LDA;
                1:       op = cpu_pkg::OP_ADD;
                2:       op = cpu_pkg::OP_SUB;
                3:       op = cpu_pkg::OP_STA;
                default: op = cpu_pkg::OP_OUT;
            endcase
            prog_mem[4'(a)] = make_instr(op, {1'b1, r[10:8]});
        end
        prog_mem[6] = make_instr(cpu_pkg::OP_OUT, 4'd0);
        prog_mem[7] = make_instr(cpu_pkg::OP_HLT, 4'd0);
    endtask

    // Taken branch gives two words, fall-through gives one
    task automatic gen_jumps();
        logic [31:0] r;
        logic        use_sub;
        fill_data();
        r       = next_random();
        use_sub = r[0];
        if (r[1]) prog_mem[9] = use_sub ? prog_mem[8] : 8'd0 - prog_mem[8];  // Force zero
        prog_mem[0] = make_instr(cpu_pkg::OP_LDA, 4'd8);
        prog_mem[1] = make_instr(use_sub ? cpu_pkg::OP_SUB : cpu_pkg::OP_ADD, 4'd9);
        prog_mem[2] = make_instr(r[2] ? cpu_pkg::OP_JZ : cpu_pkg::OP_JC, 4'd5);
        prog_mem[3] = make_instr(cpu_pkg::OP_OUT, 4'd0);
        prog_mem[4] = make_instr(cpu_pkg::OP_HLT, 4'd0);
        prog_mem[5] = make_instr(cpu_pkg::OP_OUT, 4'd0);
        prog_mem[6] = make_instr(cpu_pkg::OP_OUT, 4'd0);
        prog_mem[7] = make_instr(cpu_pkg::OP_HLT, 4'd0);
    endtask

    // Instruction-level interpreter of the ISA
    task automatic run_model();
        cpu_pkg::word_t ram [16];
        cpu_pkg::addr_t pc;
        cpu_pkg::word_t ins;
        cpu_pkg::word_t b;
        logic [8:0]     s;
        int             steps;
        logic           done;
        ram   = prog_mem;
        pc    = 4'd0;
        steps = 0;
        done  = 1'b0;
        exp_q.delete();
        while (!done && steps < 32) begin
            ins = ram[pc];
            b   = ram[ins[3:0]];
            pc  = pc + 4'd1;
            steps++;
            case (ins[7:4])
                cpu_pkg::OP_LDA: m_acc = b;
                cpu_pkg::OP_ADD: begin
                    s       = {1'b0, m_acc} + {1'b0, b};
                    m_carry = s[8];                  // Carry out of bit 7
                    m_zero  = (s[7:0] == 8'd0);
                    m_acc   = s[7:0];
                end
                cpu_pkg::OP_SUB: begin
                    m_carry = (m_acc >= b);          // No borrow
                    m_zero  = (m_acc == b);
                    m_acc   = m_acc - b;
                end
                cpu_pkg::OP_STA: ram[ins[3:0]] = m_acc;
                cpu_pkg::OP_LDI: m_acc = {4'd0, ins[3:0]};
                cpu_pkg::OP_JMP: pc = ins[3:0];
                cpu_pkg::OP_JC:  if (m_carry) pc = ins[3:0];
                cpu_pkg::OP_JZ:  if (m_zero) pc = ins[3:0];
                cpu_pkg::OP_OUT: exp_q.push_back(m_acc);
                cpu_pkg::OP_HLT: done = 1'b1;
                default: ;                           // NOP
            endcase
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < 16; a++) begin
            prog_valid <= 1'b1;
            prog_addr  <= 4'(a);
            prog_data  <= prog_mem[4'(a)];
            do begin
                step_cycle();
            end while (!smp_prog_ready);             // Write lands on the edge after ready
        end
        prog_valid <= 1'b0;
    endtask

    task automatic run_program();
        got_q.delete();
        start <= 1'b1;
        step_cycle();
        start <= 1'b0;
        do begin
            step_cycle();
        end while (!(smp_halted && !smp_out_valid)); // Drain a word still held after HLT
    endtask

    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int    errs_before;
        int    tests_failed;
        int    kind;
        string kind_name;
        clk          = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        prog_valid   = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        out_ready    = 1'b0;
        rng_state    = 32'hc67b8353;
        m_acc        = '0;
        m_carry      = 1'b0;
        m_zero       = 1'b0;
        held_valid   = 1'b0;
        held_data    = '0;
        stall_mode   = 1'b0;
        ready_hold   = 0;
        error_count  = 0;
        cycle_count  = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        step_cycle();
        check_flag("out_valid", smp_out_valid, 1'b0);
        check_flag("halted", smp_halted, 1'b1);
        check_flag("prog_ready", smp_prog_ready, 1'b1);
        $display("test reset: %s", (error_count == 0) ? "ok" : "errors");
        if (error_count != 0) tests_failed++;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = error_count;
            kind        = t % 4;
            stall_mode  = (kind == 3);               // Back-pressure runs
            case (kind)
                0: begin
                    gen_ldi_out();
                    kind_name = "ldi/out";
                end
                2: begin
                    gen_jumps();
                    kind_name = "jumps";
                end
                default: begin
                    gen_arith();
                    kind_name = stall_mode ? "arith stalled" : "arith";
                end
            endcase
            run_model();
            load_program();
            run_program();
            step_cycle();                            // CPU must stay idle after the drain
            check_count(got_q.size(), exp_q.size());
            for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
                check_word($sformatf("out_data word %0d", i), got_q[i], exp_q[i]);
            end
            check_flag("halted", smp_halted, 1'b1);
            check_flag("prog_ready", smp_prog_ready, 1'b1);
            if (error_count != errs_before) tests_failed++;
            $display("test %0d %s: %0d words, %s", t, kind_name, got_q.size(),
                     (error_count == errs_before) ? "ok" : "errors");
        end
        $display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS + 1, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/cpu_pkg.sv
hw/program_counter.sv
hw/memory_unit.sv
hw/arith_unit.sv
hw/output_port.sv
hw/control_block.sv
hw/cpu_top.sv
testbench/cpu_tb.sv

// File: Makefile
# Verilator build for the accumulator CPU

TB_TOP  = cpu_tb
RTL_TOP = cpu_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(RTL_TOP)
	verilator --lint-only --timing -f verilog.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TB_TOP) -Mdir obj_dir -o sim_cpu
	@out="$$(./obj_dir/sim_cpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir
